//--- cmd_bus_if.sv
// released command bus
`timescale 1ns/10ps
`default_nettype none

interface cmd_bus_if;

  // single cycle strobe, addr and data valid with it
  logic en;
  logic [15:0] addr;
  logic [31:0] data;
  // free running time, valid every cycle
  logic [31:0] current_time;

  // scheduler side
  modport source (
    output en,
    output addr,
    output data,
    output current_time
  );

  // pin controllers and collector, each decodes its own addresses
  modport sink (
    input en,
    input addr,
    input data,
    input current_time
  );

endinterface

`default_nettype wire

//--- cmd_scheduler.sv
// timed command release
`timescale 1ns/10ps
`default_nettype none

module cmd_scheduler (
  input wire sys_clk,
  input wire global_clock_reset,
  input wire time_restart,
  input wire mecobo_pkg::cmd_t head,
  input wire empty,
  output logic pop,
  cmd_bus_if.source bus
);

  logic [31:0] time_cnt;
  logic due;

  // free running time base
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      time_cnt <= '0;
    end else if (time_restart) begin
      time_cnt <= '0;
    end else begin
      time_cnt <= time_cnt + 32'd1;
    end
  end

  assign bus.current_time = time_cnt;

  // head is due once its time has come or passed
  assign due = ~empty && (head.start_time <= time_cnt);

  // pop now, head advances for the next compare
  assign pop = due;

  // strobe follows the pop by one cycle
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      bus.en <= 1'b0;
    end else begin
      bus.en <= due;
    end
  end

  // command payload captured with the pop
  always_ff @(posedge sys_clk) begin
    if (due) begin
      bus.addr <= head.addr;
      bus.data <= head.data;
    end
  end

endmodule

`default_nettype wire

//--- host_port.sv
// host bus decoder
`timescale 1ns/10ps
`default_nettype none
`include "mecobo_consts.svh"

module host_port (
  input wire sys_clk,
  input wire global_clock_reset,
  input wire [2:0] host_addr,
  input wire [15:0] host_data_in,
  input wire host_cs,
  input wire host_rd,
  input wire host_wr,
  output logic [15:0] host_data_out,
  output logic cmd_push,
  output mecobo_pkg::cmd_t cmd_word,
  input wire cmd_full,
  output logic sample_pop,
  input wire mecobo_pkg::sample_t sample_head,
  input wire sample_empty,
  input wire sample_overflow,
  output logic time_restart
);

  logic wr_en;
  logic rd_en;
  // staging for the first four command words
  logic [15:0] time_lo;
  logic [15:0] time_hi;
  logic [15:0] cmd_addr;
  logic [15:0] data_lo;
  logic [15:0] status_word;

  assign wr_en = host_cs & host_wr;
  assign rd_en = host_cs & host_rd;

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      case (host_addr)
        `HADDR_TIME_LO: time_lo <= host_data_in;
        `HADDR_TIME_HI: time_hi <= host_data_in;
        `HADDR_CMD_ADDR: cmd_addr <= host_data_in;
        `HADDR_DATA_LO: data_lo <= host_data_in;
        default: ;
      endcase
    end
  end

  // data hi goes straight into the word, fifo takes it at this edge
  assign cmd_push = wr_en && (host_addr == `HADDR_DATA_HI);
  assign cmd_word = '{
    start_time: {time_hi, time_lo},
    addr: cmd_addr,
    data: {host_data_in, data_lo}
  };

  assign time_restart = wr_en && (host_addr == `HADDR_TIME_RESTART);

  // pop together with the read, fifo ignores it when empty
  assign sample_pop = rd_en && (host_addr == `HADDR_SAMPLE);

  always_comb begin
    status_word = '0;
    status_word[`STAT_CMD_FULL] = cmd_full;
    status_word[`STAT_SAMPLE_EMPTY] = sample_empty;
    status_word[`STAT_OVERFLOW] = sample_overflow;
  end

  // read data held until the next read
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      host_data_out <= '0;
    end else if (rd_en) begin
      case (host_addr)
        `HADDR_TIME_LO: host_data_out <= time_lo;
        `HADDR_TIME_HI: host_data_out <= time_hi;
        `HADDR_CMD_ADDR: host_data_out <= cmd_addr;
        `HADDR_DATA_LO: host_data_out <= data_lo;
        // empty fifo reads back as zero
        `HADDR_SAMPLE: host_data_out <= sample_empty ? '0 : 16'(sample_head);
        `HADDR_STATUS: host_data_out <= status_word;
        default: host_data_out <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- mecobo_consts.svh
// mecobo shared constants
`ifndef MECOBO_CONSTS_SVH
`define MECOBO_CONSTS_SVH

// pin count, also the width of the level vector
`define N_PINS 4

// fifo sizes in entries
`define CMD_FIFO_DEPTH 8
`define SAMPLE_FIFO_DEPTH 16

// host word addresses, low 3 bits of the bus address
`define HADDR_TIME_LO 3'd0
`define HADDR_TIME_HI 3'd1
`define HADDR_CMD_ADDR 3'd2
`define HADDR_DATA_LO 3'd3
// data hi write completes and pushes the command
`define HADDR_DATA_HI 3'd4
`define HADDR_SAMPLE 3'd5
`define HADDR_STATUS 3'd6
`define HADDR_TIME_RESTART 3'd7

// command bus map, each pin owns a block of 16
`define REG_MODE 4'd0
`define REG_HALF_PERIOD 4'd1
`define COLLECT_MASK 16'd240
`define COLLECT_DIVIDER 16'd241

// status word bit positions
`define STAT_CMD_FULL 0
`define STAT_SAMPLE_EMPTY 1
`define STAT_OVERFLOW 2

`endif

//--- mecobo_core.sv
// mecobo pin engine top
`timescale 1ns/10ps
`default_nettype none
`include "mecobo_consts.svh"

module mecobo_core (
  input wire sys_clk,
  input wire global_clock_reset,
  input wire [18:0] host_addr,
  input wire [15:0] host_data_in,
  output wire [15:0] host_data_out,
  input wire host_cs,
  input wire host_rd,
  input wire host_wr,
  output wire host_irq,
  output wire [`N_PINS-1:0] pins
);

  import mecobo_pkg::*;

  // host to command fifo
  cmd_t cmd_word;
  logic cmd_push;
  logic cmd_full;
  // command fifo to scheduler
  cmd_t cmd_head;
  logic cmd_pop;
  logic cmd_empty;
  // collector to sample fifo to host
  sample_t sample_word;
  sample_t sample_head;
  logic sample_push;
  logic sample_pop;
  logic sample_empty;
  logic sample_full;
  logic sample_overflow;
  logic time_restart;

  // irq while samples wait
  assign host_irq = ~sample_empty;

  host_port u_host_port (
    .sys_clk(sys_clk),
    .global_clock_reset(global_clock_reset),
    .host_addr(host_addr[2:0]),
    .host_data_in(host_data_in),
    .host_cs(host_cs),
    .host_rd(host_rd),
    .host_wr(host_wr),
    .host_data_out(host_data_out),
    .cmd_push(cmd_push),
    .cmd_word(cmd_word),
    .cmd_full(cmd_full),
    .sample_pop(sample_pop),
    .sample_head(sample_head),
    .sample_empty(sample_empty),
    .sample_overflow(sample_overflow),
    .time_restart(time_restart)
  );

  sync_fifo #(
    .payload_t(cmd_t),
    .DEPTH(`CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .sys_clk(sys_clk),
    .global_clock_reset(global_clock_reset),
    .push(cmd_push),
    .wdata(cmd_word),
    .pop(cmd_pop),
    .head(cmd_head),
    .empty(cmd_empty),
    .full(cmd_full)
  );

  cmd_bus_if cmd_bus ();

  cmd_scheduler u_scheduler (
    .sys_clk(sys_clk),
    .global_clock_reset(global_clock_reset),
    .time_restart(time_restart),
    .head(cmd_head),
    .empty(cmd_empty),
    .pop(cmd_pop),
    .bus(cmd_bus)
  );

  // one controller per pin
  for (genvar i = 0; i < `N_PINS; i++) begin : g_pin
    pin_controller #(
      .POSITION(i)
    ) u_pin (
      .sys_clk(sys_clk),
      .global_clock_reset(global_clock_reset),
      .bus(cmd_bus),
      .pin(pins[i])
    );
  end

  sample_collector u_collector (
    .sys_clk(sys_clk),
    .global_clock_reset(global_clock_reset),
    .bus(cmd_bus),
    .pin_levels(pins),
    .sample_full(sample_full),
    .sample_push(sample_push),
    .sample_word(sample_word),
    .overflow(sample_overflow)
  );

  sync_fifo #(
    .payload_t(sample_t),
    .DEPTH(`SAMPLE_FIFO_DEPTH)
  ) u_sample_fifo (
    .sys_clk(sys_clk),
    .global_clock_reset(global_clock_reset),
    .push(sample_push),
    .wdata(sample_word),
    .pop(sample_pop),
    .head(sample_head),
    .empty(sample_empty),
    .full(sample_full)
  );

endmodule

`default_nettype wire

//--- mecobo_pkg.sv
// mecobo shared types
`default_nettype none
`include "mecobo_consts.svh"

package mecobo_pkg;

  // pin output behaviour
  typedef enum logic [1:0] {
    MODE_LOW = 2'd0,
    MODE_HIGH = 2'd1,
    MODE_SQUARE = 2'd2
  } pin_mode_e;

  // one timed command as stored in the command fifo
  typedef struct packed {
    logic [31:0] start_time;
    logic [15:0] addr;
    logic [31:0] data;
  } cmd_t;

  // stamp is the low bits of the time counter
  typedef struct packed {
    logic [11:0] stamp;
    logic [`N_PINS-1:0] levels;
  } sample_t;

endpackage

`default_nettype wire

//--- pin_controller.sv
// per-pin wave controller
`timescale 1ns/10ps
`default_nettype none
`include "mecobo_consts.svh"

module pin_controller #(
  parameter int POSITION = 0
) (
  input wire sys_clk,
  input wire global_clock_reset,
  cmd_bus_if.sink bus,
  output logic pin
);

  import mecobo_pkg::*;

  // this pin's block on the command bus
  localparam logic [15:0] MODE_ADDR = {12'(POSITION), `REG_MODE};
  localparam logic [15:0] HALF_ADDR = {12'(POSITION), `REG_HALF_PERIOD};

  pin_mode_e mode;
  logic [31:0] half_period;
  logic [31:0] tick;
  logic mode_wr;
  logic half_wr;

  assign mode_wr = bus.en && (bus.addr == MODE_ADDR);
  assign half_wr = bus.en && (bus.addr == HALF_ADDR);

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      half_period <= 32'd1;
    end else if (half_wr) begin
      half_period <= bus.data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      mode <= MODE_LOW;
      pin <= 1'b0;
      tick <= '0;
    end else if (mode_wr) begin
      // new level shows the cycle after the strobe
      mode <= pin_mode_e'(bus.data[1:0]);
      pin <= (bus.data[1:0] == MODE_HIGH);
      // square restarts low with a fresh count
      tick <= '0;
    end else begin
      case (mode)
        MODE_HIGH: pin <= 1'b1;
        MODE_SQUARE: begin
          // toggle every half_period cycles
          if (tick + 32'd1 >= half_period) begin
            pin <= ~pin;
            tick <= '0;
          end else begin
            tick <= tick + 32'd1;
          end
        end
        default: pin <= 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
mecobo_pkg.sv
cmd_bus_if.sv
sync_fifo.sv
host_port.sv
cmd_scheduler.sv
pin_controller.sv
sample_collector.sv
mecobo_core.sv
tb_mecobo.sv

//--- sample_collector.sv
// timed pin sampler
`timescale 1ns/10ps
`default_nettype none
`include "mecobo_consts.svh"

module sample_collector (
  input wire sys_clk,
  input wire global_clock_reset,
  cmd_bus_if.sink bus,
  input wire [`N_PINS-1:0] pin_levels,
  input wire sample_full,
  output logic sample_push,
  output mecobo_pkg::sample_t sample_word,
  output logic overflow
);

  logic [`N_PINS-1:0] mask;
  logic [15:0] divider;
  logic [15:0] div_cnt;
  logic div_wr;
  logic active;
  logic fire;
  logic pending;

  assign div_wr = bus.en && (bus.addr == `COLLECT_DIVIDER);

  // collector registers
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      mask <= '0;
      divider <= '0;
    end else if (bus.en) begin
      if (bus.addr == `COLLECT_MASK) begin
        mask <= bus.data[`N_PINS-1:0];
      end
      if (div_wr) begin
        divider <= bus.data[15:0];
      end
    end
  end

  // idle unless both mask and divider set
  assign active = (mask != '0) && (divider != '0);
  assign fire = active && (div_cnt + 16'd1 >= divider);

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      div_cnt <= '0;
      pending <= 1'b0;
      overflow <= 1'b0;
    end else begin
      // divider write restarts the rate count
      if (div_wr || !active || fire) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 16'd1;
      end
      pending <= fire;
      // sticky until reset
      if (pending && sample_full) begin
        overflow <= 1'b1;
      end
    end
  end

  // sample formed on fire, pushed the next cycle
  always_ff @(posedge sys_clk) begin
    if (fire) begin
      sample_word.stamp <= bus.current_time[11:0];
      sample_word.levels <= pin_levels & mask;
    end
  end

  // full fifo drops the sample
  assign sample_push = pending & ~sample_full;

endmodule

`default_nettype wire

//--- sync_fifo.sv
// show-ahead synchronous fifo
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [15:0],
  parameter int DEPTH = 8
) (
  input wire sys_clk,
  input wire global_clock_reset,
  input wire push,
  input wire payload_t wdata,
  input wire pop,
  output payload_t head,
  output logic empty,
  output logic full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0] count;
  logic do_push;
  logic do_pop;

  // drop push when full, drop pop when empty
  assign do_push = push & ~full;
  assign do_pop = pop & ~empty;

  assign empty = (count == '0);
  assign full = (count == (PTR_W + 1)'(DEPTH));

  // oldest entry always on the output
  assign head = mem[rd_ptr];

  // storage
  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // pointers and fill level
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tb_mecobo.sv
// mecobo pin engine testbench
`timescale 1ns/10ps
`default_nettype none
`include "mecobo_consts.svh"

module tb_mecobo;

  import mecobo_pkg::*;

  // whole sequence runs well under a thousand cycles, wide margin
  localparam int MAX_CYCLES = 20000;

  logic sys_clk;
  logic global_clock_reset;
  logic [18:0] host_addr;
  logic [15:0] host_data_in;
  wire [15:0] host_data_out;
  logic host_cs;
  logic host_rd;
  logic host_wr;
  wire host_irq;
  wire [`N_PINS-1:0] pins;
  logic [31:0] lfsr;
  int cycle_count = 0;

  mecobo_core dut (
    .sys_clk(sys_clk),
    .global_clock_reset(global_clock_reset),
    .host_addr(host_addr),
    .host_data_in(host_data_in),
    .host_data_out(host_data_out),
    .host_cs(host_cs),
    .host_rd(host_rd),
    .host_wr(host_wr),
    .host_irq(host_irq),
    .pins(pins)
  );

  // 10 ns period
  always #5 sys_clk = ~sys_clk;

  // watchdog
  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  // status empty bit agrees with the irq line seen at the read edge
  property status_empty_matches_irq;
    @(posedge sys_clk) disable iff (global_clock_reset)
      (host_cs && host_rd && (host_addr[2:0] == `HADDR_STATUS)) |=>
        (host_data_out[`STAT_SAMPLE_EMPTY] == !$past(host_irq));
  endproperty

  assert property (status_empty_matches_irq) else begin
    $display("** Error at %0t ns: status sample empty bit expected %0b got %0b", $time,
             !$sampled(host_data_out[`STAT_SAMPLE_EMPTY]),
             $sampled(host_data_out[`STAT_SAMPLE_EMPTY]));
    $display("SOME TESTS FAILED");
    $fatal(1, "status mismatch");
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // one cycle write strobe, called on a falling edge
  task automatic host_write(input logic [2:0] addr, input logic [15:0] data);
    host_addr = {16'd0, addr};
    host_data_in = data;
    host_cs = 1'b1;
    host_wr = 1'b1;
    @(negedge sys_clk);
    host_cs = 1'b0;
    host_wr = 1'b0;
  endtask

  // read data is registered at the edge inside the strobe
  task automatic host_read(input logic [2:0] addr, output logic [15:0] data);
    host_addr = {16'd0, addr};
    host_cs = 1'b1;
    host_rd = 1'b1;
    @(negedge sys_clk);
    host_cs = 1'b0;
    host_rd = 1'b0;
    data = host_data_out;
  endtask

  // five words, the last one pushes
  task automatic write_cmd(input logic [31:0] start, input logic [15:0] addr,
                           input logic [31:0] data);
    host_write(`HADDR_TIME_LO, start[15:0]);
    host_write(`HADDR_TIME_HI, start[31:16]);
    host_write(`HADDR_CMD_ADDR, addr);
    host_write(`HADDR_DATA_LO, data[15:0]);
    host_write(`HADDR_DATA_HI, data[31:16]);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge sys_clk);
  endtask

  task automatic wait_irq();
    while (!host_irq) @(negedge sys_clk);
  endtask

  initial begin
    logic [15:0] rdata;
    int pin_sel;
    int now;
    int gap;
    logic [31:0] t_start;
    logic [31:0] half;
    logic prev_level;
    logic [`N_PINS-1:0] levels;
    logic [`N_PINS-1:0] mask;
    logic [15:0] divider;
    logic [11:0] prev_stamp;
    logic [11:0] next_stamp;
    sys_clk = 1'b0;
    global_clock_reset = 1'b1;
    host_addr = '0;
    host_data_in = '0;
    host_cs = 1'b0;
    host_rd = 1'b0;
    host_wr = 1'b0;
    lfsr = 32'h5b25;
    repeat (5) @(negedge sys_clk);
    global_clock_reset = 1'b0;

    // reset state
    check_value("pins", 0, pins);
    check_value("host_irq", 0, host_irq);
    host_read(`HADDR_STATUS, rdata);
    check_value("status", 1 << `STAT_SAMPLE_EMPTY, rdata);

    // timed release, own count starts at the restart edge
    pin_sel = rand_bits(2);
    t_start = 16 + rand_bits(4);
    host_write(`HADDR_TIME_RESTART, 16'd0);
    now = 0;
    write_cmd(t_start, 16'(pin_sel * 16 + `REG_MODE), MODE_HIGH);
    now = 5;
    // due at T, on the bus at T+1, on the pin at T+2
    while (now < t_start + 2) begin
      check_value($sformatf("pins[%0d]", pin_sel), 0, pins[pin_sel]);
      @(negedge sys_clk);
      now++;
    end
    check_value($sformatf("pins[%0d]", pin_sel), 1, pins[pin_sel]);

    // past start times, released in fifo order
    pin_sel = rand_bits(2);
    write_cmd(0, 16'(pin_sel * 16 + `REG_MODE), MODE_HIGH);
    wait_cycles(2);
    check_value($sformatf("pins[%0d]", pin_sel), 1, pins[pin_sel]);
    write_cmd(0, 16'(pin_sel * 16 + `REG_MODE), MODE_LOW);
    wait_cycles(2);
    check_value($sformatf("pins[%0d]", pin_sel), 0, pins[pin_sel]);
    wait_cycles(6);
    check_value($sformatf("pins[%0d]", pin_sel), 0, pins[pin_sel]);

    // square wave edge spacing
    pin_sel = rand_bits(2);
    half = 1 + rand_bits(3);
    write_cmd(0, 16'(pin_sel * 16 + `REG_HALF_PERIOD), half);
    write_cmd(0, 16'(pin_sel * 16 + `REG_MODE), MODE_SQUARE);
    prev_level = pins[pin_sel];
    while (pins[pin_sel] == prev_level) @(negedge sys_clk);
    repeat (6) begin
      prev_level = pins[pin_sel];
      gap = 0;
      while (pins[pin_sel] == prev_level) begin
        @(negedge sys_clk);
        gap++;
      end
      check_value("square edge gap", half, gap);
    end

    // fixed levels, then sampling
    levels = rand_bits(`N_PINS);
    for (int i = 0; i < `N_PINS; i++) begin
      write_cmd(0, 16'(i * 16 + `REG_MODE), levels[i] ? MODE_HIGH : MODE_LOW);
    end
    mask = rand_bits(`N_PINS);
    if (mask == '0) begin
      mask = 'b1;
    end
    divider = 3 + rand_bits(3);
    write_cmd(0, `COLLECT_MASK, mask);
    write_cmd(0, `COLLECT_DIVIDER, divider);
    wait_irq();
    host_read(`HADDR_SAMPLE, rdata);
    check_value("sample levels", levels & mask, rdata[`N_PINS-1:0]);
    prev_stamp = rdata[15:4];
    repeat (4) begin
      wait_irq();
      host_read(`HADDR_SAMPLE, rdata);
      check_value("sample levels", levels & mask, rdata[`N_PINS-1:0]);
      // stamp wraps at 12 bits
      next_stamp = prev_stamp + divider[11:0];
      check_value("sample stamp", next_stamp, rdata[15:4]);
      prev_stamp = rdata[15:4];
    end

    // overflow with no reads
    host_read(`HADDR_STATUS, rdata);
    while (!rdata[`STAT_OVERFLOW]) begin
      wait_cycles(3);
      host_read(`HADDR_STATUS, rdata);
    end
    // stop sampling, full fifo drops anything still in flight
    write_cmd(0, `COLLECT_MASK, 0);
    wait_cycles(3);
    // a full fifo holds exactly its depth
    for (int i = 0; i < `SAMPLE_FIFO_DEPTH; i++) begin
      check_value("host_irq", 1, host_irq);
      host_read(`HADDR_SAMPLE, rdata);
      check_value("sample levels", levels & mask, rdata[`N_PINS-1:0]);
    end
    check_value("host_irq", 0, host_irq);
    host_read(`HADDR_STATUS, rdata);
    check_value("status", (1 << `STAT_SAMPLE_EMPTY) | (1 << `STAT_OVERFLOW), rdata);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
